//--- design/scramble_params.svh
`ifndef SCRAMBLE_PARAMS_SVH
`define SCRAMBLE_PARAMS_SVH

// ========================================================================
// Widths
// ========================================================================
`define SCR_PORT_W        8
`define SCR_JOY_W         11
`define SCR_KEY_W         11     // [10] toggle, [9] pressed, [8:0] code

// Download bus
`define SCR_DL_GAME       8'd1   // Game number
`define SCR_DL_DIP        8'd254 // DIP switch bytes
`define SCR_DIP_COUNT     4

// 1.79 MHz strobe, period is reload + 1
`define SCR_CE179_RELOAD  4'd13

// ========================================================================
// Keyboard codes
// ========================================================================
// Arrows compare the low byte so the E0 prefix is ignored
`define SCR_KEY_UP        8'h75
`define SCR_KEY_DOWN      8'h72
`define SCR_KEY_LEFT      8'h6B
`define SCR_KEY_RIGHT     8'h74

`define SCR_KEY_CTRL      9'h014
`define SCR_KEY_SPACE     9'h029
`define SCR_KEY_F1        9'h005
`define SCR_KEY_F2        9'h006
`define SCR_KEY_1         9'h016
`define SCR_KEY_2         9'h01E
`define SCR_KEY_5         9'h02E
`define SCR_KEY_6         9'h036
`define SCR_KEY_R         9'h02D
`define SCR_KEY_F         9'h02B
`define SCR_KEY_D         9'h023
`define SCR_KEY_G         9'h034
`define SCR_KEY_A         9'h01C
`define SCR_KEY_S         9'h01B

`endif

//--- design/scramble_pkg.sv
package scramble_pkg;

	// Game number as written by the loader on index 1
	typedef enum logic [7:0]
	{
		game_scramble = 8'd0,
		game_amidar   = 8'd1,
		game_frogger  = 8'd2,
		game_scobra   = 8'd3,
		game_tazman   = 8'd4,
		game_armorcar = 8'd5,
		game_moonwar  = 8'd6,
		game_spdcoin  = 8'd7,
		game_calipso  = 8'd8,
		game_darkplnt = 8'd9,
		game_anteater = 8'd10,
		game_losttomb = 8'd11,
		game_theend   = 8'd12,
		game_mars     = 8'd13,
		game_stratgyx = 8'd14,
		game_turtles  = 8'd15,
		game_minefld  = 8'd16,
		game_rescue   = 8'd17,
		game_mimonkey = 8'd18
	} game_e;

	// Merged controls, active high
	typedef struct packed
	{
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic       fire_a;
		logic       fire_b;
		logic       fire_c;
		logic       fire_d;
		logic       fire_e;
		logic       start1;
		logic       start2;
		logic       coin;
		logic [3:0] pad;
	} controls_t;

	// Held keyboard buttons of one player
	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic start;
		logic coin;
		logic pad;
	} btn_t;

endpackage

//--- design/clock_enables.sv
`include "scramble_params.svh"

module clock_enables
(
	input  logic clk_sys,
	input  logic rst,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79
);

	logic [1:0] div_q;     // 12/6 MHz phase counter
	logic [3:0] div179_q;  // 1.79 MHz down-counter

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			div_q    <= '0;
			div179_q <= '0;
			ce_12    <= 1'b0;
			ce_6p    <= 1'b0;
			ce_6n    <= 1'b0;
			ce_1p79  <= 1'b0;
		end
		else
		begin
			div_q <= div_q + 2'd1;
			ce_12 <= div_q[0];
			ce_6p <= div_q[0] & ~div_q[1];  // Phase 1
			ce_6n <= div_q[0] &  div_q[1];  // Phase 3, two cycles later

			if (div179_q == '0)
			begin
				div179_q <= `SCR_CE179_RELOAD;
				ce_1p79  <= 1'b1;
			end
			else
			begin
				div179_q <= div179_q - 4'd1;
				ce_1p79  <= 1'b0;
			end
		end
	end

endmodule

//--- design/ps2_key_decoder.sv
`include "scramble_params.svh"

module ps2_key_decoder
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic [`SCR_KEY_W-1:0]  ps2_key,
	output scramble_pkg::btn_t     kb_p1,
	output scramble_pkg::btn_t     kb_p2
);

	import scramble_pkg::*;

	logic       old_toggle;
	logic       key_event;
	logic       pressed;
	logic [8:0] key_code;

	assign pressed   = ps2_key[9];
	assign key_code  = ps2_key[8:0];
	assign key_event = ps2_key[10] != old_toggle;

	// Registered copy of the toggle bit
	always_ff @(posedge clk_sys)
	begin
		old_toggle <= ps2_key[10];
	end

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			kb_p1 <= '0;
			kb_p2 <= '0;
		end
		else if (key_event)
		begin
			// Arrows with or without the extended prefix
			case (key_code[7:0])
				`SCR_KEY_UP:    kb_p1.up    <= pressed;
				`SCR_KEY_DOWN:  kb_p1.down  <= pressed;
				`SCR_KEY_LEFT:  kb_p1.left  <= pressed;
				`SCR_KEY_RIGHT: kb_p1.right <= pressed;
				default: ;
			endcase

			case (key_code)
				`SCR_KEY_CTRL:  kb_p1.fire1 <= pressed;
				`SCR_KEY_SPACE: kb_p1.fire2 <= pressed;
				`SCR_KEY_F1:    kb_p1.start <= pressed;
				`SCR_KEY_1:     kb_p1.start <= pressed;
				`SCR_KEY_F2:    kb_p2.start <= pressed;
				`SCR_KEY_2:     kb_p2.start <= pressed;
				`SCR_KEY_5:     kb_p1.coin  <= pressed;
				`SCR_KEY_6:     kb_p2.coin  <= pressed;

				// Player two cluster
				`SCR_KEY_R:     kb_p2.up    <= pressed;
				`SCR_KEY_F:     kb_p2.down  <= pressed;
				`SCR_KEY_D:     kb_p2.left  <= pressed;
				`SCR_KEY_G:     kb_p2.right <= pressed;
				`SCR_KEY_A:     kb_p2.fire1 <= pressed;
				`SCR_KEY_S:     kb_p2.fire2 <= pressed;
				default: ;
			endcase
		end
	end

endmodule

//--- design/game_config.sv
`include "scramble_params.svh"

module game_config
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   ioctl_wr,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_index,
	input  logic [`SCR_PORT_W-1:0] ioctl_dout,
	output scramble_pkg::game_e    game,
	output logic [`SCR_PORT_W-1:0] dip_a,
	output logic [`SCR_PORT_W-1:0] dip_b,
	output logic [`SCR_PORT_W-1:0] dip_c,
	output logic [`SCR_PORT_W-1:0] dip_d
);

	import scramble_pkg::*;

	localparam int DIP_AW = $clog2(`SCR_DIP_COUNT);

	logic [`SCR_PORT_W-1:0] dip_q [`SCR_DIP_COUNT];
	logic                   game_wr;
	logic                   dip_wr;

	assign game_wr = ioctl_wr && (ioctl_index == `SCR_DL_GAME);
	assign dip_wr  = ioctl_wr && (ioctl_index == `SCR_DL_DIP) && (ioctl_addr[24:DIP_AW] == '0);

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			game <= game_scramble;
			for (int i = 0; i < `SCR_DIP_COUNT; i++)
				dip_q[i] <= '1;  // All switches open
		end
		else
		begin
			if (game_wr)
				game <= game_e'(ioctl_dout);
			if (dip_wr)
				dip_q[ioctl_addr[DIP_AW-1:0]] <= ioctl_dout;
		end
	end

	assign dip_a = dip_q[0];
	assign dip_b = dip_q[1];
	assign dip_c = dip_q[2];
	assign dip_d = dip_q[3];

endmodule

//--- design/input_port_mapper.sv
`include "scramble_params.svh"

module input_port_mapper
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  scramble_pkg::btn_t     kb_p1,
	input  scramble_pkg::btn_t     kb_p2,
	input  logic [`SCR_JOY_W-1:0]  joy1,
	input  logic [`SCR_JOY_W-1:0]  joy2,
	input  logic                   alt_mode,
	input  scramble_pkg::game_e    game,
	input  logic [`SCR_PORT_W-1:0] dip_a,
	input  logic [`SCR_PORT_W-1:0] dip_b,
	input  logic [`SCR_PORT_W-1:0] dip_c,
	input  logic [`SCR_PORT_W-1:0] dip_d,
	output logic [`SCR_PORT_W-1:0] port_a,
	output logic [`SCR_PORT_W-1:0] port_b,
	output logic [`SCR_PORT_W-1:0] port_c,
	output logic [`SCR_PORT_W-1:0] port_d,
	output logic [7:0]             hwsel,
	output logic                   landscape,
	output logic                   fourfire,
	output logic                   galaxian_video
);

	import scramble_pkg::*;

	controls_t              c;
	logic [`SCR_JOY_W-1:0]  joy;
	logic [`SCR_PORT_W-1:0] lay_a, lay_b, lay_c, lay_d;  // Active-high layouts
	logic [7:0]             hwsel_d;
	logic                   landscape_d, fourfire_d, galaxian_d;

	assign joy = joy1 | joy2;

	// ========================================================================
	// Control merge
	// ========================================================================
	always_comb
	begin
		c        = '0;
		c.up     = kb_p1.up    | kb_p2.up    | joy1[3] | joy2[3];
		c.down   = kb_p1.down  | kb_p2.down  | joy1[2] | joy2[2];
		c.left   = kb_p1.left  | kb_p2.left  | joy1[1] | joy2[1];
		c.right  = kb_p1.right | kb_p2.right | joy1[0] | joy2[0];
		c.fire_a = kb_p1.fire1 | kb_p2.fire1 | joy[4];
		c.fire_b = kb_p1.fire2 | kb_p2.fire2 | joy[5];
		c.fire_c = joy[6];
		c.fire_d = joy[7];
		c.fire_e = joy[8];
		c.start1 = kb_p1.start | joy[8];  // Shares the fire e line
		c.start2 = kb_p2.start | joy[9];
		c.coin   = kb_p1.coin  | kb_p2.coin  | joy[10];
	end

	// ========================================================================
	// Per-game layout
	// ========================================================================
	always_comb
	begin
		hwsel_d     = 8'd0;
		landscape_d = 1'b0;
		fourfire_d  = 1'b0;
		galaxian_d  = 1'b0;
		lay_a = {c.coin, 1'b0, c.left, c.right, c.fire_a, 1'b0, c.fire_b, c.up};
		lay_b = {c.start1, c.start2, c.left, c.right, c.fire_a, c.fire_b, 2'b00};
		lay_c = {1'b0, c.down, 1'b0, c.up, 3'b000, c.down};
		lay_d = 8'h00;

		case (game)
			game_frogger: hwsel_d = 8'd1;
			game_scobra, game_armorcar, game_moonwar: hwsel_d = 8'd2;
			game_darkplnt: hwsel_d = 8'd4;  // Spinner game, default layout
			game_tazman:
			begin
				hwsel_d = 8'd2;
				lay_a = {c.coin, 1'b0, c.left, c.right, c.down, c.up, c.fire_a, c.fire_b};
				lay_b = 8'h00;
				lay_c = {1'b0, c.start2, 5'b00000, c.start1};
			end
			game_spdcoin:
			begin
				hwsel_d = 8'd2;
				lay_a = {c.coin, 1'b0, c.left, c.right, c.start2, 1'b0, c.start1, 1'b0};
				lay_b = 8'h00;
				lay_c = 8'h00;
			end
			game_calipso:
			begin
				hwsel_d = 8'd3;
				lay_a = {c.coin, 1'b0, c.left, c.right, c.down, c.up, 1'b0, c.start2 | c.fire_a};
				lay_b = {2'b00, c.left, c.right, c.down, c.up, 2'b00};
				lay_c = {7'b0000000, c.fire_a | c.start1};
			end
			game_anteater:
			begin
				hwsel_d = 8'd6;
				lay_a = {c.coin, 1'b0, c.left, c.right, c.down, c.up, 1'b0, c.fire_a};
				lay_b = {1'b0, c.fire_a, c.left, c.right, c.up, c.down, 2'b00};
				lay_c = {1'b0, c.start2, 5'b00000, c.start1};
			end
			game_losttomb:
			begin
				hwsel_d    = 8'd7;
				fourfire_d = 1'b1;
				lay_a = {c.coin, 1'b0, c.left, c.right, c.down, c.up, c.start1, c.start2};
				lay_b = alt_mode ?
					{1'b0, c.fire_e | c.fire_a, c.left, c.right, c.down, c.up, 2'b00} :
					{1'b0, c.fire_e, c.fire_d, c.fire_a, c.fire_b, c.fire_c, 2'b00};
				lay_c = 8'h00;
			end
			game_theend: galaxian_d = 1'b1;
			game_mars:
			begin
				hwsel_d    = 8'd10;
				fourfire_d = 1'b1;
				if (alt_mode)  // Second stick on the directions
				begin
					lay_a = {c.coin, 1'b0, c.left, c.right, c.left, c.right, 1'b0, c.up};
					lay_b = {c.start1, c.start2, c.left, c.right, c.left, c.right, 2'b00};
					lay_c = {c.up, c.down, c.down, c.up, 3'b000, c.down};
					lay_d = {c.up, 1'b0, c.down, 5'b00000};
				end
				else
				begin
					lay_a = {c.coin, 1'b0, c.left, c.right, c.fire_d, c.fire_a, 1'b0, c.up};
					lay_b = {c.start1, c.start2, c.left, c.right, c.fire_d, c.fire_a, 2'b00};
					lay_c = {c.fire_c, c.down, c.fire_b, c.up, 3'b000, c.down};
					lay_d = {c.fire_c, 1'b0, c.fire_b, 5'b00000};
				end
			end
			game_stratgyx:
			begin
				hwsel_d     = 8'd5;
				landscape_d = 1'b1;
				lay_c = {c.fire_c, c.down, c.fire_c, c.up, 3'b000, c.down};
			end
			game_turtles:
			begin
				hwsel_d = 8'd11;
				lay_a = {c.coin, 1'b0, c.left, c.right, c.fire_a, 2'b00, c.up};
				lay_b = {c.start1, c.start2, c.left, c.right, c.fire_a, 3'b000};
			end
			game_minefld, game_rescue:
			begin
				hwsel_d    = (game == game_rescue) ? 8'd9 : 8'd8;
				fourfire_d = 1'b1;
				lay_a = {c.coin, 1'b0, c.left, c.right, c.down, c.up, 1'b0, c.start1};
				lay_b = alt_mode ? {2'b00, c.left, c.right, c.down, c.up, 2'b00} :
					{2'b00, c.fire_d, c.fire_a, c.fire_b, c.fire_c, 2'b00};
				lay_c = {1'b0, c.start2, 5'b00000, c.start1};
			end
			game_mimonkey: hwsel_d = 8'd12;
			default: ;
		endcase
	end

	// Ports are active low, gated by the DIP bytes
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			port_a <= '1;
			port_b <= '1;
			port_c <= '1;
			port_d <= '1;
			hwsel          <= 8'd0;
			landscape      <= 1'b0;
			fourfire       <= 1'b0;
			galaxian_video <= 1'b0;
		end
		else
		begin
			port_a <= dip_a & ~lay_a;
			port_b <= dip_b & ~lay_b;
			port_c <= dip_c & ~lay_c;
			port_d <= dip_d & ~lay_d;
			hwsel          <= hwsel_d;
			landscape      <= landscape_d;
			fourfire       <= fourfire_d;
			galaxian_video <= galaxian_d;
		end
	end

endmodule

//--- design/scramble_inputs.sv
`include "scramble_params.svh"

module scramble_inputs
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic [`SCR_KEY_W-1:0]  ps2_key,
	input  logic                   ioctl_wr,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_index,
	input  logic [`SCR_PORT_W-1:0] ioctl_dout,
	input  logic [`SCR_JOY_W-1:0]  joy1,
	input  logic [`SCR_JOY_W-1:0]  joy2,
	input  logic                   alt_mode,
	output logic                   ce_12,
	output logic                   ce_6p,
	output logic                   ce_6n,
	output logic                   ce_1p79,
	output logic [`SCR_PORT_W-1:0] port_a,
	output logic [`SCR_PORT_W-1:0] port_b,
	output logic [`SCR_PORT_W-1:0] port_c,
	output logic [`SCR_PORT_W-1:0] port_d,
	output logic [7:0]             hwsel,
	output logic                   landscape,
	output logic                   fourfire,
	output logic                   galaxian_video
);

	import scramble_pkg::*;

	btn_t                   kb_p1, kb_p2;
	game_e                  game;
	logic [`SCR_PORT_W-1:0] dip_a, dip_b, dip_c, dip_d;

	clock_enables u_ce
	(
		.clk_sys, .rst, .ce_12, .ce_6p, .ce_6n, .ce_1p79
	);

	// Event sources
	ps2_key_decoder u_kbd
	(
		.clk_sys, .rst, .ps2_key, .kb_p1, .kb_p2
	);

	game_config u_cfg
	(
		.clk_sys, .rst, .ioctl_wr, .ioctl_addr, .ioctl_index, .ioctl_dout,
		.game, .dip_a, .dip_b, .dip_c, .dip_d
	);

	// Consumer
	input_port_mapper u_map
	(
		.clk_sys, .rst, .kb_p1, .kb_p2, .joy1, .joy2, .alt_mode, .game,
		.dip_a, .dip_b, .dip_c, .dip_d,
		.port_a, .port_b, .port_c, .port_d,
		.hwsel, .landscape, .fourfire, .galaxian_video
	);

endmodule

//--- testbench/scramble_inputs_props.sv
`include "scramble_params.svh"

module scramble_inputs_props
(
	input logic                   clk_sys,
	input logic                   rst,
	input logic                   ce_6p,
	input logic                   ce_6n,
	input logic                   ce_1p79,
	input logic [`SCR_PORT_W-1:0] port_a
);

	timeunit 1ns;
	timeprecision 100ps;

	// Phase n follows phase p by two cycles and never overlaps it
	assert property (@(posedge clk_sys) disable iff (rst) ce_6p |-> !ce_6n ##2 ce_6n)
	else $error("ce_6n not two cycles after ce_6p or high together with it");

	// 1.79 MHz strobe lasts one cycle and repeats every 14
	assert property (@(posedge clk_sys) disable iff (rst) ce_1p79 |=> !ce_1p79 ##13 ce_1p79)
	else $error("ce_1p79 not a single-cycle strobe with a period of 14 cycles");

	// Idle port right after reset
	assert property (@(posedge clk_sys) rst |=> (port_a == 8'hFF))
	else $error("port_a not idle in the cycle after reset");

endmodule

bind scramble_inputs scramble_inputs_props props0
(
	.clk_sys, .rst, .ce_6p, .ce_6n, .ce_1p79, .port_a
);

//--- testbench/tb_scramble_inputs.sv
`include "scramble_params.svh"

module tb_scramble_inputs;

	timeunit 1ns;
	timeprecision 100ps;

	import scramble_pkg::*;

	localparam int reset_cycles   = 3;
	localparam int timeout_cycles = 600;
	localparam int ce_window      = 56;  // Multiple of every strobe period
	localparam int ce179_period   = 14;  // 1.79 MHz strobe period in cycles

	// Controls in joystick bit order
	localparam logic [`SCR_JOY_W-1:0] ctl_right  = 11'h001;
	localparam logic [`SCR_JOY_W-1:0] ctl_left   = 11'h002;
	localparam logic [`SCR_JOY_W-1:0] ctl_down   = 11'h004;
	localparam logic [`SCR_JOY_W-1:0] ctl_up     = 11'h008;
	localparam logic [`SCR_JOY_W-1:0] ctl_fire_a = 11'h010;
	localparam logic [`SCR_JOY_W-1:0] ctl_fire_b = 11'h020;
	localparam logic [`SCR_JOY_W-1:0] ctl_fire_d = 11'h080;
	localparam logic [`SCR_JOY_W-1:0] ctl_start1 = 11'h100;
	localparam logic [`SCR_JOY_W-1:0] ctl_start2 = 11'h200;
	localparam logic [`SCR_JOY_W-1:0] ctl_coin   = 11'h400;

	logic                   clk_sys;
	logic                   rst;
	logic [`SCR_KEY_W-1:0]  ps2_key;
	logic                   ioctl_wr;
	logic [24:0]            ioctl_addr;
	logic [7:0]             ioctl_index;
	logic [`SCR_PORT_W-1:0] ioctl_dout;
	logic [`SCR_JOY_W-1:0]  joy1;
	logic [`SCR_JOY_W-1:0]  joy2;
	logic                   alt_mode;
	logic                   ce_12, ce_6p, ce_6n, ce_1p79;
	logic [`SCR_PORT_W-1:0] port_a, port_b, port_c, port_d;
	logic [7:0]             hwsel;
	logic                   landscape, fourfire, galaxian_video;

	int     error_count = 0;
	int     check_count = 0;
	int     test_count  = 0;
	int     test_errors = 0;
	int     cycle_count = 0;
	integer seed;

	scramble_inputs dut0 (.*);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout after %0d cycles, a test did not complete", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	// ========================================================================
	// Expected port values from the reference layouts
	// ========================================================================
	function automatic logic [7:0] default_a(input logic [7:0] dip, input logic [10:0] j);
		return dip & ~{j[10], 1'b0, j[1], j[0], j[4], 1'b0, j[5], j[3]};
	endfunction

	function automatic logic [7:0] tazman_a(input logic [7:0] dip, input logic [10:0] j);
		return dip & ~{j[10], 1'b0, j[1], j[0], j[2], j[3], j[4], j[5]};
	endfunction

	// Open DIP switches assumed
	function automatic logic [7:0] losttomb_b(input logic alt, input logic [10:0] j);
		if (alt)
			return ~{1'b0, j[8] | j[4], j[1], j[0], j[2], j[3], 2'b00};
		else
			return ~{1'b0, j[8], j[7], j[4], j[5], j[6], 2'b00};
	endfunction

	function automatic logic [7:0] dip_value(input logic [1:0] idx);
		case (idx)
			2'd0:    return 8'hA5;
			2'd1:    return 8'h3C;
			2'd2:    return 8'h96;
			default: return 8'h5F;
		endcase
	endfunction

	// ========================================================================
	// Drivers and checks
	// ========================================================================
	task automatic wait_edges(input int n);
		repeat (n) @(posedge clk_sys);
		#1;  // Inputs change just after the edge
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %s = %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_total(input string name, input int got, input int exp);
		check_count++;
		assert (got == exp)
		else
		begin
			$display("[FAIL] %s = %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic start_test();
		test_errors = error_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count == test_errors)
			$display("Test %s passed", name);
		else
			$display("Test %s failed with %0d errors", name, error_count - test_errors);
	endtask

	// New toggle value marks the event
	task automatic send_key(input logic [8:0] code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, code};
		wait_edges(2);
	endtask

	task automatic tap_key(input logic [8:0] code, input logic [10:0] ctl);
		send_key(code, 1'b1);
		check_byte("port_a", port_a, default_a(8'hFF, ctl));
		send_key(code, 1'b0);
		check_byte("port_a", port_a, 8'hFF);
	endtask

	task automatic load_byte(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		ioctl_wr    = 1'b1;
		wait_edges(1);
		ioctl_wr    = 1'b0;
		wait_edges(1);  // Mapper picks up the new config
	endtask

	// ========================================================================
	// Tests
	// ========================================================================
	task automatic test_reset_state();
		start_test();
		check_byte("port_a", port_a, 8'hFF);
		check_byte("port_b", port_b, 8'hFF);
		check_byte("port_c", port_c, 8'hFF);
		check_byte("port_d", port_d, 8'hFF);
		check_byte("hwsel", hwsel, 8'h00);
		check_byte("flags", {5'd0, landscape, fourfire, galaxian_video}, 8'h00);
		end_test("reset state");
	endtask

	task automatic test_clock_enables();
		int n12, n6p, n6n, n179;
		n12  = 0;
		n6p  = 0;
		n6n  = 0;
		n179 = 0;
		start_test();
		repeat (ce_window)
		begin
			wait_edges(1);
			if (ce_12)
				n12++;
			if (ce_6p)
				n6p++;
			if (ce_6n)
				n6n++;
			if (ce_1p79)
				n179++;
		end
		check_total("ce_12 count", n12, ce_window / 2);
		check_total("ce_6p count", n6p, ce_window / 4);
		check_total("ce_6n count", n6n, ce_window / 4);
		check_total("ce_1p79 count", n179, ce_window / ce179_period);
		end_test("clock enables");
	endtask

	task automatic test_keyboard();
		start_test();
		tap_key(`SCR_KEY_CTRL, ctl_fire_a);
		tap_key({1'b0, `SCR_KEY_UP}, ctl_up);
		tap_key({1'b1, `SCR_KEY_UP}, ctl_up);  // Extended prefix
		tap_key(`SCR_KEY_5, ctl_coin);
		tap_key(`SCR_KEY_A, ctl_fire_a);       // Player two fire
		end_test("keyboard");
	endtask

	task automatic test_joystick();
		logic [`SCR_JOY_W-1:0] j;
		start_test();
		repeat (8)
		begin
			j = 11'($random(seed)) & (ctl_right | ctl_left | ctl_up | ctl_fire_a | ctl_fire_b);
			joy1 = j;
			wait_edges(1);
			check_byte("port_a", port_a, default_a(8'hFF, j));
			joy1 = '0;
			joy2 = j;
			wait_edges(1);
			check_byte("port_a", port_a, default_a(8'hFF, j));
			joy2 = '0;
		end
		joy1 = ctl_start1;
		wait_edges(1);
		check_byte("port_b[7]", {7'd0, port_b[7]}, 8'h00);
		joy1 = '0;
		joy2 = ctl_start2;
		wait_edges(1);
		check_byte("port_b[6]", {7'd0, port_b[6]}, 8'h00);
		joy2 = ctl_coin;
		wait_edges(1);
		check_byte("port_a", port_a, default_a(8'hFF, ctl_coin));
		joy2 = '0;
		wait_edges(1);
		end_test("joystick merge");
	endtask

	task automatic test_game_select();
		start_test();
		load_byte(`SCR_DL_GAME, 25'd0, game_frogger);
		check_byte("hwsel", hwsel, 8'd1);
		check_byte("fourfire", {7'd0, fourfire}, 8'h00);
		load_byte(`SCR_DL_GAME, 25'd0, game_anteater);
		check_byte("hwsel", hwsel, 8'd6);

		load_byte(`SCR_DL_GAME, 25'd0, game_tazman);
		check_byte("fourfire", {7'd0, fourfire}, 8'h00);
		joy1 = ctl_down | ctl_fire_a;
		wait_edges(1);
		check_byte("port_a", port_a, tazman_a(8'hFF, joy1));
		check_byte("port_b", port_b, 8'hFF);
		joy1 = ctl_coin | ctl_fire_b | ctl_left | ctl_right;
		wait_edges(1);
		check_byte("port_a", port_a, tazman_a(8'hFF, joy1));

		load_byte(`SCR_DL_GAME, 25'd0, game_losttomb);
		check_byte("fourfire", {7'd0, fourfire}, 8'h01);
		joy1 = ctl_fire_a | ctl_fire_d | ctl_left;
		wait_edges(1);
		check_byte("port_b", port_b, losttomb_b(1'b0, joy1));
		alt_mode = 1'b1;
		wait_edges(1);
		check_byte("port_b", port_b, losttomb_b(1'b1, joy1));

		joy1     = '0;
		alt_mode = 1'b0;

		// Board flags
		load_byte(`SCR_DL_GAME, 25'd0, game_stratgyx);
		check_byte("landscape", {7'd0, landscape}, 8'h01);
		check_byte("galaxian_video", {7'd0, galaxian_video}, 8'h00);
		load_byte(`SCR_DL_GAME, 25'd0, game_theend);
		check_byte("landscape", {7'd0, landscape}, 8'h00);
		check_byte("galaxian_video", {7'd0, galaxian_video}, 8'h01);

		load_byte(`SCR_DL_GAME, 25'd0, game_scramble);
		check_byte("hwsel", hwsel, 8'd0);
		end_test("game selection");
	endtask

	task automatic test_dip_load();
		start_test();
		for (int i = 0; i < `SCR_DIP_COUNT; i++)
			load_byte(`SCR_DL_DIP, 25'(i), dip_value(2'(i)));
		check_byte("port_a", port_a, dip_value(2'd0));
		check_byte("port_b", port_b, dip_value(2'd1));
		check_byte("port_c", port_c, dip_value(2'd2));
		check_byte("port_d", port_d, dip_value(2'd3));
		joy1 = ctl_up;
		wait_edges(1);
		check_byte("port_a", port_a, default_a(dip_value(2'd0), ctl_up));
		joy1 = '0;

		// Out of range addresses leave the bytes alone
		load_byte(`SCR_DL_DIP, 25'h0000004, 8'h00);
		load_byte(`SCR_DL_DIP, 25'h1000001, 8'h00);
		check_byte("port_a", port_a, dip_value(2'd0));
		check_byte("port_b", port_b, dip_value(2'd1));
		check_byte("port_c", port_c, dip_value(2'd2));
		check_byte("port_d", port_d, dip_value(2'd3));
		end_test("DIP loading");
	endtask

	initial
	begin
		seed        = 32'h17dc_805c;
		rst         = 1'b1;
		ps2_key     = '0;
		ioctl_wr    = 1'b0;
		ioctl_addr  = '0;
		ioctl_index = '0;
		ioctl_dout  = '0;
		joy1        = '0;
		joy2        = '0;
		alt_mode    = 1'b0;
		repeat (reset_cycles) @(posedge clk_sys);
		#1;
		rst = 1'b0;

		test_reset_state();
		test_clock_enables();
		test_keyboard();
		test_joystick();
		test_game_select();
		test_dip_load();

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- scramble_inputs.f
+incdir+design
design/scramble_pkg.sv
design/clock_enables.sv
design/ps2_key_decoder.sv
design/game_config.sv
design/input_port_mapper.sv
design/scramble_inputs.sv
testbench/scramble_inputs_props.sv
testbench/tb_scramble_inputs.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scramble_inputs
FILELIST  ?= scramble_inputs.f
BUILD_DIR ?= build
SIM_BIN   ?= $(BUILD_DIR)/V$(TOP)
LOG       ?= $(BUILD_DIR)/sim.log
FAIL_MSG  ?= Finished with errors

SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR)"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(abspath $(SIM_BIN))

test: $(SIM_BIN)
	@mkdir -p $(dir $(LOG))
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
